//--- logic/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN - 1 : 0] addr_t;
    typedef logic [XLEN - 1 : 0] data_t;
    typedef logic [XLEN - 1 : 0] inst_t;
    typedef logic [4 : 0]        reg_id_t;

    // ALU operations
    typedef logic [2 : 0] alu_op_t;
    localparam alu_op_t ALU_ADD    = 3'd0;
    localparam alu_op_t ALU_SUB    = 3'd1;
    localparam alu_op_t ALU_AND    = 3'd2;
    localparam alu_op_t ALU_OR     = 3'd3;
    localparam alu_op_t ALU_XOR    = 3'd4;
    localparam alu_op_t ALU_PASS_B = 3'd5;

    // Register write source
    typedef logic [1 : 0] wb_src_t;
    localparam wb_src_t WB_ALU  = 2'd0;
    localparam wb_src_t WB_LOAD = 2'd1;
    localparam wb_src_t WB_LINK = 2'd2;

    typedef logic [1 : 0] jmp_t;
    localparam jmp_t JMP_NONE = 2'd0;
    localparam jmp_t JMP_BEQ  = 2'd1;
    localparam jmp_t JMP_BNE  = 2'd2;
    localparam jmp_t JMP_JAL  = 2'd3;

    // RV32I major opcodes
    localparam logic [6 : 0] OP_REG    = 7'b0110011;
    localparam logic [6 : 0] OP_IMM    = 7'b0010011;
    localparam logic [6 : 0] OP_LUI    = 7'b0110111;
    localparam logic [6 : 0] OP_LOAD   = 7'b0000011;
    localparam logic [6 : 0] OP_STORE  = 7'b0100011;
    localparam logic [6 : 0] OP_BRANCH = 7'b1100011;
    localparam logic [6 : 0] OP_JAL    = 7'b1101111;
    localparam logic [6 : 0] OP_SYSTEM = 7'b1110011;

    typedef enum logic [2 : 0] {
        ST_FETCH     = 3'd0,
        ST_DECODE    = 3'd1,
        ST_EXECUTE   = 3'd2,
        ST_MEMORY    = 3'd3,
        ST_WRITEBACK = 3'd4
    } stage_e;

endpackage

//--- logic/dec_if.sv
`timescale 1ns/1ps

interface dec_if;
    import rv_core_pkg::*;

    alu_op_t alu_op;
    data_t   op_a;
    data_t   op_b;
    // Store data and the second branch operand
    data_t   rs2_data;
    reg_id_t rd;
    logic    reg_wr_en;
    wb_src_t wb_src;
    logic    mem_rd;
    logic    mem_wr;
    jmp_t    jmp_type;
    data_t   jmp_ofs;
    addr_t   pc;
    logic    end_req;

    modport decoder (
        output alu_op, op_a, op_b, rs2_data, rd, reg_wr_en, wb_src,
               mem_rd, mem_wr, jmp_type, jmp_ofs, pc, end_req
    );

    modport consumer (
        input  alu_op, op_a, op_b, rs2_data, rd, reg_wr_en, wb_src,
               mem_rd, mem_wr, jmp_type, jmp_ofs, pc, end_req
    );

endinterface

//--- logic/gpr.sv
`timescale 1ns/1ps

module gpr(
    input  logic                i_sys_clk,
    input  logic                i_rst_n,
    input  rv_core_pkg::reg_id_t i_rs1_id,
    input  rv_core_pkg::reg_id_t i_rs2_id,
    output rv_core_pkg::data_t  o_rs1_data,
    output rv_core_pkg::data_t  o_rs2_data,
    output rv_core_pkg::data_t  o_a0_data,
    input  logic                i_wr_en,
    input  rv_core_pkg::reg_id_t i_wr_id,
    input  rv_core_pkg::data_t  i_wr_data
);
    import rv_core_pkg::*;

    // x0 has no storage
    data_t r_regs [31 : 1];

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                r_regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_id != '0)) begin
            r_regs[i_wr_id] <= i_wr_data;
        end
    end

    assign o_rs1_data = (i_rs1_id == '0) ? '0 : r_regs[i_rs1_id];
    assign o_rs2_data = (i_rs2_id == '0) ? '0 : r_regs[i_rs2_id];
    assign o_a0_data  = r_regs[10];

    a_wr_id_known: assert property (
        @(posedge i_sys_clk) disable iff (!i_rst_n)
        i_wr_en |-> !$isunknown(i_wr_id)
    );

endmodule

//--- logic/ifu.sv
`timescale 1ns/1ps

module ifu #(
    parameter rv_core_pkg::addr_t BOOT_ADDR = '0
)(
    input  logic               i_sys_clk,
    input  logic               i_rst_n,
    input  logic               i_jmp_en,
    input  rv_core_pkg::addr_t i_jmp_pc,
    input  logic               i_halt,
    output rv_core_pkg::addr_t o_pc,
    output logic               o_fetch_stb,
    output logic               o_decode_stb,
    output logic               o_execute_stb,
    output logic               o_memory_stb,
    output logic               o_writeback_stb
);
    import rv_core_pkg::*;

    stage_e r_state;
    stage_e w_state_nxt;
    addr_t  r_pc;

    always_comb begin
        case (r_state)
            ST_FETCH:     w_state_nxt = i_halt ? ST_FETCH : ST_DECODE;
            ST_DECODE:    w_state_nxt = ST_EXECUTE;
            ST_EXECUTE:   w_state_nxt = ST_MEMORY;
            ST_MEMORY:    w_state_nxt = ST_WRITEBACK;
            default:      w_state_nxt = ST_FETCH;
        endcase
    end

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state <= ST_FETCH;
            r_pc    <= BOOT_ADDR;
        end else begin
            r_state <= w_state_nxt;
            // Redirect or step once the instruction retires
            if (r_state == ST_WRITEBACK) begin
                r_pc <= i_jmp_en ? i_jmp_pc : r_pc + 32'd4;
            end
        end
    end

    assign o_pc            = r_pc;
    assign o_fetch_stb     = (r_state == ST_FETCH) && !i_halt;
    assign o_decode_stb    = (r_state == ST_DECODE);
    assign o_execute_stb   = (r_state == ST_EXECUTE);
    assign o_memory_stb    = (r_state == ST_MEMORY);
    assign o_writeback_stb = (r_state == ST_WRITEBACK);

    a_one_stage: assert property (
        @(posedge i_sys_clk) disable iff (!i_rst_n)
        $onehot({i_halt, o_fetch_stb, o_decode_stb, o_execute_stb,
                 o_memory_stb, o_writeback_stb})
    );

endmodule

//--- logic/idu.sv
`timescale 1ns/1ps

module idu(
    input  logic                 i_sys_clk,
    input  logic                 i_rst_n,
    input  logic                 i_fetch_stb,
    input  logic                 i_decode_stb,
    input  rv_core_pkg::inst_t   i_inst,
    input  rv_core_pkg::addr_t   i_pc,
    output rv_core_pkg::reg_id_t o_rs1_id,
    output rv_core_pkg::reg_id_t o_rs2_id,
    input  rv_core_pkg::data_t   i_rs1_data,
    input  rv_core_pkg::data_t   i_rs2_data,
    dec_if.decoder               dec
);
    import rv_core_pkg::*;

    inst_t   r_inst;
    data_t   w_imm_i;
    data_t   w_imm_s;
    data_t   w_imm_b;
    data_t   w_imm_u;
    data_t   w_imm_j;
    alu_op_t w_alu_op;
    data_t   w_op_b;
    data_t   w_jmp_ofs;
    wb_src_t w_wb_src;
    logic    w_reg_wr;
    logic    w_mem_rd;
    logic    w_mem_wr;
    jmp_t    w_jmp_type;
    logic    w_end_req;

    always_ff @(posedge i_sys_clk) begin
        if (i_fetch_stb) begin
            r_inst <= i_inst;
        end
    end

    assign o_rs1_id = r_inst[19:15];
    assign o_rs2_id = r_inst[24:20];

    assign w_imm_i = {{20{r_inst[31]}}, r_inst[31:20]};
    assign w_imm_s = {{20{r_inst[31]}}, r_inst[31:25], r_inst[11:7]};
    assign w_imm_b = {{19{r_inst[31]}}, r_inst[31], r_inst[7], r_inst[30:25], r_inst[11:8], 1'b0};
    assign w_imm_u = {r_inst[31:12], 12'b0};
    assign w_imm_j = {{11{r_inst[31]}}, r_inst[31], r_inst[19:12], r_inst[20], r_inst[30:21], 1'b0};

    // Anything unrecognised falls through as a no-op
    always_comb begin
        w_alu_op   = ALU_ADD;
        w_op_b     = i_rs2_data;
        w_jmp_ofs  = w_imm_b;
        w_wb_src   = WB_ALU;
        w_reg_wr   = 1'b0;
        w_mem_rd   = 1'b0;
        w_mem_wr   = 1'b0;
        w_jmp_type = JMP_NONE;
        w_end_req  = 1'b0;
        case (r_inst[6:0])
            OP_REG: begin
                w_reg_wr = 1'b1;
                case (r_inst[14:12])
                    3'b000:  w_alu_op = r_inst[30] ? ALU_SUB : ALU_ADD;
                    3'b100:  w_alu_op = ALU_XOR;
                    3'b110:  w_alu_op = ALU_OR;
                    3'b111:  w_alu_op = ALU_AND;
                    default: w_reg_wr = 1'b0;
                endcase
            end
            OP_IMM: begin
                w_op_b   = w_imm_i;
                w_reg_wr = (r_inst[14:12] == 3'b000);
            end
            OP_LUI: begin
                w_alu_op = ALU_PASS_B;
                w_op_b   = w_imm_u;
                w_reg_wr = 1'b1;
            end
            OP_LOAD: begin
                w_op_b   = w_imm_i;
                w_wb_src = WB_LOAD;
                w_mem_rd = (r_inst[14:12] == 3'b010);
                w_reg_wr = w_mem_rd;
            end
            OP_STORE: begin
                w_op_b   = w_imm_s;
                w_mem_wr = (r_inst[14:12] == 3'b010);
            end
            OP_BRANCH: begin
                if (r_inst[14:12] == 3'b000) begin
                    w_jmp_type = JMP_BEQ;
                end else if (r_inst[14:12] == 3'b001) begin
                    w_jmp_type = JMP_BNE;
                end
            end
            OP_JAL: begin
                w_jmp_ofs  = w_imm_j;
                w_jmp_type = JMP_JAL;
                w_wb_src   = WB_LINK;
                w_reg_wr   = 1'b1;
            end
            OP_SYSTEM: w_end_req = (r_inst[31:7] == 25'h0002000);
            default:   w_reg_wr = 1'b0;
        endcase
    end

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dec.reg_wr_en <= 1'b0;
            dec.mem_rd    <= 1'b0;
            dec.mem_wr    <= 1'b0;
            dec.jmp_type  <= JMP_NONE;
            dec.end_req   <= 1'b0;
        end else if (i_decode_stb) begin
            dec.reg_wr_en <= w_reg_wr;
            dec.mem_rd    <= w_mem_rd;
            dec.mem_wr    <= w_mem_wr;
            dec.jmp_type  <= w_jmp_type;
            dec.end_req   <= w_end_req;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (i_decode_stb) begin
            dec.alu_op   <= w_alu_op;
            dec.op_a     <= i_rs1_data;
            dec.op_b     <= w_op_b;
            dec.rs2_data <= i_rs2_data;
            dec.rd       <= r_inst[11:7];
            dec.wb_src   <= w_wb_src;
            dec.jmp_ofs  <= w_jmp_ofs;
            dec.pc       <= i_pc;
        end
    end

endmodule

//--- logic/exu.sv
`timescale 1ns/1ps

module exu(
    input  logic               i_sys_clk,
    input  logic               i_rst_n,
    input  logic               i_execute_stb,
    dec_if.consumer            dec,
    output rv_core_pkg::data_t o_result,
    output logic               o_jmp_en,
    output rv_core_pkg::addr_t o_jmp_pc
);
    import rv_core_pkg::*;

    data_t w_alu_res;
    logic  w_take;
    data_t r_result;
    logic  r_jmp_en;
    addr_t r_jmp_pc;

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:    w_alu_res = dec.op_a - dec.op_b;
            ALU_AND:    w_alu_res = dec.op_a & dec.op_b;
            ALU_OR:     w_alu_res = dec.op_a | dec.op_b;
            ALU_XOR:    w_alu_res = dec.op_a ^ dec.op_b;
            ALU_PASS_B: w_alu_res = dec.op_b;
            default:    w_alu_res = dec.op_a + dec.op_b;
        endcase
    end

    // Branches compare rs1 against the rs2 value
    always_comb begin
        case (dec.jmp_type)
            JMP_BEQ: w_take = (dec.op_a == dec.rs2_data);
            JMP_BNE: w_take = (dec.op_a != dec.rs2_data);
            JMP_JAL: w_take = 1'b1;
            default: w_take = 1'b0;
        endcase
    end

    // Decision is refreshed by every instruction
    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_jmp_en <= 1'b0;
        end else if (i_execute_stb) begin
            r_jmp_en <= w_take;
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (i_execute_stb) begin
            r_result <= w_alu_res;
            r_jmp_pc <= dec.pc + dec.jmp_ofs;
        end
    end

    assign o_result = r_result;
    assign o_jmp_en = r_jmp_en;
    assign o_jmp_pc = r_jmp_pc;

endmodule

//--- logic/lsu.sv
`timescale 1ns/1ps

module lsu(
    input  logic                 i_sys_clk,
    input  logic                 i_rst_n,
    input  logic                 i_memory_stb,
    input  logic                 i_writeback_stb,
    dec_if.consumer              dec,
    input  rv_core_pkg::data_t   i_result,
    input  rv_core_pkg::data_t   i_ram_rd_data,
    output logic                 o_ram_rd_en,
    output rv_core_pkg::addr_t   o_ram_rd_addr,
    output logic                 o_ram_wr_en,
    output rv_core_pkg::addr_t   o_ram_wr_addr,
    output rv_core_pkg::data_t   o_ram_wr_data,
    output logic                 o_gpr_wr_en,
    output rv_core_pkg::reg_id_t o_gpr_wr_id,
    output rv_core_pkg::data_t   o_gpr_wr_data
);
    import rv_core_pkg::*;

    data_t r_load_data;

    // Word access with the address straight from the ALU
    assign o_ram_rd_en   = i_memory_stb && dec.mem_rd;
    assign o_ram_rd_addr = i_result;
    assign o_ram_wr_en   = i_memory_stb && dec.mem_wr;
    assign o_ram_wr_addr = i_result;
    assign o_ram_wr_data = dec.rs2_data;

    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_load_data <= '0;
        end else if (o_ram_rd_en) begin
            r_load_data <= i_ram_rd_data;
        end
    end

    assign o_gpr_wr_en = i_writeback_stb && dec.reg_wr_en;
    assign o_gpr_wr_id = dec.rd;

    always_comb begin
        case (dec.wb_src)
            WB_LOAD: o_gpr_wr_data = r_load_data;
            WB_LINK: o_gpr_wr_data = dec.pc + 32'd4;
            default: o_gpr_wr_data = i_result;
        endcase
    end

    a_rd_wr_excl: assert property (
        @(posedge i_sys_clk) disable iff (!i_rst_n)
        !(o_ram_rd_en && o_ram_wr_en)
    );

endmodule

//--- logic/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter rv_core_pkg::addr_t BOOT_ADDR = '0
)(
    input  logic               i_sys_clk,
    input  logic               i_rst_n,

    input  rv_core_pkg::inst_t i_rom_rd_data,
    output logic               o_rom_rd_en,
    output rv_core_pkg::addr_t o_rom_rd_addr,

    input  rv_core_pkg::data_t i_ram_rd_data,
    output logic               o_ram_rd_en,
    output rv_core_pkg::addr_t o_ram_rd_addr,
    output logic               o_ram_wr_en,
    output rv_core_pkg::addr_t o_ram_wr_addr,
    output rv_core_pkg::data_t o_ram_wr_data,

    output logic               o_end_flag,
    output rv_core_pkg::data_t o_end_data
);
    import rv_core_pkg::*;

    addr_t   w_pc;
    logic    w_fetch_stb;
    logic    w_decode_stb;
    logic    w_execute_stb;
    logic    w_memory_stb;
    logic    w_writeback_stb;
    logic    w_jmp_en;
    addr_t   w_jmp_pc;
    reg_id_t w_rs1_id;
    reg_id_t w_rs2_id;
    data_t   w_rs1_data;
    data_t   w_rs2_data;
    data_t   w_exu_res;
    logic    w_gpr_wr_en;
    reg_id_t w_gpr_wr_id;
    data_t   w_gpr_wr_data;
    logic    r_end_flag;

    dec_if u_dec();

    // Sticky once EBREAK retires
    always_ff @(posedge i_sys_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_end_flag <= 1'b0;
        end else if (w_writeback_stb && u_dec.end_req) begin
            r_end_flag <= 1'b1;
        end
    end

    assign o_rom_rd_en   = !r_end_flag;
    assign o_rom_rd_addr = w_pc;
    assign o_end_flag    = r_end_flag;

    gpr u_gpr(
        .i_sys_clk (i_sys_clk    ), .i_rst_n   (i_rst_n      ),
        .i_rs1_id  (w_rs1_id     ), .i_rs2_id  (w_rs2_id     ),
        .o_rs1_data(w_rs1_data   ), .o_rs2_data(w_rs2_data   ),
        .o_a0_data (o_end_data   ), .i_wr_en   (w_gpr_wr_en  ),
        .i_wr_id   (w_gpr_wr_id  ), .i_wr_data (w_gpr_wr_data)
    );

    ifu #(.BOOT_ADDR(BOOT_ADDR)) u_ifu(
        .i_sys_clk    (i_sys_clk    ), .i_rst_n        (i_rst_n        ),
        .i_jmp_en     (w_jmp_en     ), .i_jmp_pc       (w_jmp_pc       ),
        .i_halt       (r_end_flag   ), .o_pc           (w_pc           ),
        .o_fetch_stb  (w_fetch_stb  ), .o_decode_stb   (w_decode_stb   ),
        .o_execute_stb(w_execute_stb), .o_memory_stb   (w_memory_stb   ),
        .o_writeback_stb(w_writeback_stb)
    );

    idu u_idu(
        .i_sys_clk (i_sys_clk    ), .i_rst_n     (i_rst_n      ),
        .i_fetch_stb(w_fetch_stb ), .i_decode_stb(w_decode_stb ),
        .i_inst    (i_rom_rd_data), .i_pc        (w_pc         ),
        .o_rs1_id  (w_rs1_id     ), .o_rs2_id    (w_rs2_id     ),
        .i_rs1_data(w_rs1_data   ), .i_rs2_data  (w_rs2_data   ),
        .dec       (u_dec        )
    );

    exu u_exu(
        .i_sys_clk    (i_sys_clk    ), .i_rst_n (i_rst_n  ),
        .i_execute_stb(w_execute_stb), .dec     (u_dec    ),
        .o_result     (w_exu_res    ), .o_jmp_en(w_jmp_en ),
        .o_jmp_pc     (w_jmp_pc     )
    );

    lsu u_lsu(
        .i_sys_clk    (i_sys_clk    ), .i_rst_n        (i_rst_n        ),
        .i_memory_stb (w_memory_stb ), .i_writeback_stb(w_writeback_stb),
        .dec          (u_dec        ), .i_result       (w_exu_res      ),
        .i_ram_rd_data(i_ram_rd_data), .o_ram_rd_en    (o_ram_rd_en    ),
        .o_ram_rd_addr(o_ram_rd_addr), .o_ram_wr_en    (o_ram_wr_en    ),
        .o_ram_wr_addr(o_ram_wr_addr), .o_ram_wr_data  (o_ram_wr_data  ),
        .o_gpr_wr_en  (w_gpr_wr_en  ), .o_gpr_wr_id    (w_gpr_wr_id    ),
        .o_gpr_wr_data(w_gpr_wr_data)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
)(
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

//--- verification/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    localparam int          CLK_PERIOD  = 40;
    localparam logic [31:0] BOOT_ADDR   = 32'h0000_0100;
    localparam int          NUM_PROGS   = 6;
    localparam int          MAX_LEN     = 24;
    localparam int          TAIL        = 10;
    localparam int          WATCHDOG_NS = NUM_PROGS * (MAX_LEN * 5 + TAIL + 5) * CLK_PERIOD * 2;
    localparam logic [31:0] EBREAK      = 32'h0010_0073;

    // Instruction kinds of the generated programs
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_ADDI = 5;
    localparam int K_LUI  = 6;
    localparam int K_LW   = 7;
    localparam int K_SW   = 8;
    localparam int K_BEQ  = 9;
    localparam int K_BNE  = 10;
    localparam int K_JAL  = 11;
    localparam int K_EBRK = 12;

    logic        clk;
    logic        rst_n;
    logic [31:0] rom_rd_data;
    logic        rom_rd_en;
    logic [31:0] rom_rd_addr;
    logic [31:0] rom_offset;
    logic [31:0] ram_rd_data;
    logic        ram_rd_en;
    logic [31:0] ram_rd_addr;
    logic        ram_wr_en;
    logic [31:0] ram_wr_addr;
    logic [31:0] ram_wr_data;
    logic        end_flag;
    logic [31:0] end_data;

    logic [31:0] rom [64];
    logic [31:0] ram [64];
    logic [31:0] lfsr_state;
    int          prog_kind [MAX_LEN];
    int          prog_rd [MAX_LEN];
    int          prog_rs1 [MAX_LEN];
    int          prog_rs2 [MAX_LEN];
    logic [31:0] prog_imm [MAX_LEN];
    logic [31:0] exp_pc_q [$];
    logic [31:0] exp_st_addr_q [$];
    logic [31:0] exp_st_data_q [$];
    logic [31:0] exp_ld_addr_q [$];
    logic [31:0] exp_a0;
    logic [31:0] halt_addr;
    int          n_checks;
    int          n_errors;
    int          cyc;
    int          pc_idx;
    int          st_idx;
    int          ld_idx;
    int          end_cyc;
    bit          checking;
    bit          prog_done;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) clock_gen_inst (.o_clk(clk));

    cpu #(.BOOT_ADDR(BOOT_ADDR)) cpu_inst (
        .i_sys_clk    (clk        ),
        .i_rst_n      (rst_n      ),
        .i_rom_rd_data(rom_rd_data),
        .o_rom_rd_en  (rom_rd_en  ),
        .o_rom_rd_addr(rom_rd_addr),
        .i_ram_rd_data(ram_rd_data),
        .o_ram_rd_en  (ram_rd_en  ),
        .o_ram_rd_addr(ram_rd_addr),
        .o_ram_wr_en  (ram_wr_en  ),
        .o_ram_wr_addr(ram_wr_addr),
        .o_ram_wr_data(ram_wr_data),
        .o_end_flag   (end_flag   ),
        .o_end_data   (end_data   )
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [31:0] ram_fill(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] encode_inst(input int i);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        rd  = 5'(prog_rd[i]);
        rs1 = 5'(prog_rs1[i]);
        rs2 = 5'(prog_rs2[i]);
        imm = prog_imm[i];
        case (prog_kind[i])
            K_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:   return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:   return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:    return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:   return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_ADDI:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_LUI:   return {imm[31:12], rd, 7'b0110111};
            K_LW:    return {imm[11:0], 5'd0, 3'b010, rd, 7'b0000011};
            K_SW:    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
            K_BEQ:   return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            K_BNE:   return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            K_JAL:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            default: return EBREAK;
        endcase
    endfunction

    // Forward-only control flow, so every program reaches its EBREAK
    task automatic gen_program(output int n);
        int          k;
        int          hop;
        logic [31:0] raw;
        n = 16 + int'(take_bits(3));
        for (int i = 0; i < 64; i++) begin
            rom[i] = EBREAK;
        end
        for (int i = 0; i < n - 1; i++) begin
            k           = int'(take_bits(4));
            prog_rd[i]  = int'(take_bits(4));
            prog_rs1[i] = int'(take_bits(4));
            prog_rs2[i] = int'(take_bits(4));
            raw         = take_bits(20);
            hop         = 1 + int'(take_bits(2));
            if (hop > n - 1 - i) begin
                hop = n - 1 - i;
            end
            case (k)
                0, 1:      prog_kind[i] = K_ADD;
                2:         prog_kind[i] = K_SUB;
                3:         prog_kind[i] = K_AND;
                4:         prog_kind[i] = K_OR;
                5:         prog_kind[i] = K_XOR;
                6, 7:      prog_kind[i] = K_ADDI;
                8:         prog_kind[i] = K_LUI;
                9, 10, 15: prog_kind[i] = K_SW;
                11:        prog_kind[i] = K_LW;
                12:        prog_kind[i] = K_BEQ;
                13:        prog_kind[i] = K_BNE;
                default:   prog_kind[i] = K_JAL;
            endcase
            case (prog_kind[i])
                K_ADDI:     prog_imm[i] = {{20{raw[11]}}, raw[11:0]};
                K_LUI:      prog_imm[i] = {raw[19:0], 12'b0};
                K_LW, K_SW: prog_imm[i] = {26'b0, raw[3:0], 2'b00};
                default:    prog_imm[i] = 32'(hop * 4);
            endcase
            rom[i] = encode_inst(i);
        end
        prog_kind[n - 1] = K_EBRK;
        rom[n - 1] = EBREAK;
    endtask

    function automatic void run_reference(input int n);
        logic [31:0] regs [16];
        logic [31:0] mem [64];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        int          pc_i;
        int          nxt;
        bit          halted;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = ram_fill(32'(i * 4));
        end
        exp_pc_q.delete();
        exp_st_addr_q.delete();
        exp_st_data_q.delete();
        exp_ld_addr_q.delete();
        pc_i   = 0;
        halted = 1'b0;
        while (!halted && pc_i < n) begin
            exp_pc_q.push_back(BOOT_ADDR + 32'(pc_i * 4));
            a   = regs[prog_rs1[pc_i]];
            b   = regs[prog_rs2[pc_i]];
            res = '0;
            wr  = 1'b1;
            nxt = pc_i + 1;
            case (prog_kind[pc_i])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_ADDI: res = a + prog_imm[pc_i];
                K_LUI:  res = prog_imm[pc_i];
                K_LW: begin
                    res = mem[prog_imm[pc_i][7:2]];
                    exp_ld_addr_q.push_back(prog_imm[pc_i]);
                end
                K_SW: begin
                    wr = 1'b0;
                    mem[prog_imm[pc_i][7:2]] = b;
                    exp_st_addr_q.push_back(prog_imm[pc_i]);
                    exp_st_data_q.push_back(b);
                end
                K_BEQ, K_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (prog_kind[pc_i] == K_BEQ)) begin
                        nxt = pc_i + int'(prog_imm[pc_i]) / 4;
                    end
                end
                K_JAL: begin
                    res = BOOT_ADDR + 32'(pc_i * 4 + 4);
                    nxt = pc_i + int'(prog_imm[pc_i]) / 4;
                end
                default: begin
                    wr     = 1'b0;
                    halted = 1'b1;
                end
            endcase
            // x0 stays zero
            if (wr && prog_rd[pc_i] != 0) begin
                regs[prog_rd[pc_i]] = res;
            end
            pc_i = nxt;
        end
        exp_a0 = regs[10];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic report_error(input string msg);
        n_errors++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    // Memory models that answer in the same cycle
    assign rom_offset  = rom_rd_addr - BOOT_ADDR;
    assign rom_rd_data = rom[rom_offset[7:2]];
    assign ram_rd_data = ram_rd_en ? ram[ram_rd_addr[7:2]] : 32'h0;

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 64; i++) begin
                ram[i] <= ram_fill(32'(i * 4));
            end
        end else if (ram_wr_en) begin
            ram[ram_wr_addr[7:2]] <= ram_wr_data;
        end
    end

    // Sampled on the falling edge with one fetch every five cycles
    always @(negedge clk) begin
        if (checking) begin
            if (!end_flag && end_cyc == 0) begin
                if (cyc % 5 == 0) begin
                    check_value("o_rom_rd_en", 32'(rom_rd_en), 32'h1);
                    if (pc_idx < exp_pc_q.size()) begin
                        check_value("o_rom_rd_addr", rom_rd_addr, exp_pc_q[pc_idx]);
                    end else begin
                        report_error("fetch beyond the end of the reference trace");
                    end
                    pc_idx++;
                end
            end else begin
                check_value("o_end_flag", 32'(end_flag), 32'h1);
                check_value("o_rom_rd_en", 32'(rom_rd_en), 32'h0);
                if (end_cyc == 0) begin
                    check_value("o_end_data", end_data, exp_a0);
                    check_value("fetch count", pc_idx, exp_pc_q.size());
                    check_value("store count", st_idx, exp_st_addr_q.size());
                    check_value("load count", ld_idx, exp_ld_addr_q.size());
                    // The pc steps past the EBREAK as it retires
                    halt_addr = exp_pc_q[exp_pc_q.size() - 1] + 32'd4;
                end
                check_value("o_rom_rd_addr", rom_rd_addr, halt_addr);
                end_cyc++;
                if (end_cyc == TAIL) begin
                    checking  = 1'b0;
                    prog_done = 1'b1;
                end
            end
            if (ram_wr_en) begin
                if (st_idx < exp_st_addr_q.size()) begin
                    check_value("o_ram_wr_addr", ram_wr_addr, exp_st_addr_q[st_idx]);
                    check_value("o_ram_wr_data", ram_wr_data, exp_st_data_q[st_idx]);
                end else begin
                    report_error("RAM write that the reference program never makes");
                end
                st_idx++;
            end
            if (ram_rd_en) begin
                if (ld_idx < exp_ld_addr_q.size()) begin
                    check_value("o_ram_rd_addr", ram_rd_addr, exp_ld_addr_q[ld_idx]);
                end else begin
                    report_error("RAM read that the reference program never makes");
                end
                ld_idx++;
            end
            cyc++;
        end
    end

    initial begin
        int n;
        rst_n      = 1'b0;
        lfsr_state = 32'hdf41_4369;
        checking   = 1'b0;
        prog_done  = 1'b0;
        n_checks   = 0;
        n_errors   = 0;
        cyc        = 0;
        pc_idx     = 0;
        st_idx     = 0;
        ld_idx     = 0;
        end_cyc    = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = EBREAK;
        end
        for (int p = 0; p < NUM_PROGS; p++) begin
            @(posedge clk);
            rst_n <= 1'b0;
            gen_program(n);
            run_reference(n);
            @(negedge clk);
            check_value("o_rom_rd_addr", rom_rd_addr, BOOT_ADDR);
            check_value("o_ram_rd_en", 32'(ram_rd_en), 32'h0);
            check_value("o_ram_wr_en", 32'(ram_wr_en), 32'h0);
            check_value("o_end_flag", 32'(end_flag), 32'h0);
            repeat (4) @(posedge clk);
            rst_n   <= 1'b1;
            cyc      = 0;
            pc_idx   = 0;
            st_idx   = 0;
            ld_idx   = 0;
            end_cyc  = 0;
            checking = 1'b1;
            wait (prog_done);
            prog_done = 1'b0;
        end
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: end flag not raised within the %0d ns watchdog limit", WATCHDOG_NS);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- rv_core.f
logic/rv_core_pkg.sv
logic/dec_if.sv
logic/gpr.sv
logic/ifu.sv
logic/idu.sv
logic/exu.sv
logic/lsu.sv
logic/cpu.sv
verification/tb_clock_gen.sv
verification/tb_cpu.sv

//--- Makefile
TOP := tb_cpu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f rv_core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f rv_core.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Verification failed" sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
